// ==== gb_loader_pkg.sv ====
// Shared widths, download kinds, file indices and boot constants; import into each loader module
`default_nettype none

package gb_loader_pkg;

	////////////////////////////////////////
	// Host download stream widths
	////////////////////////////////////////

	localparam int WORD_W       = 16;
	localparam int INDEX_W      = 8;
	localparam int ADDR_W       = 25;

	// Low byte-address bits that pick a word inside one cheat record
	localparam int CHEAT_ADDR_W = 4;

	typedef logic [WORD_W-1:0] word_t;

	// Kind of download, as seen by every consumer of the word stream
	typedef enum logic [2:0] {
		KIND_NONE     = 3'd0,
		KIND_CART     = 3'd1,
		KIND_PALETTE  = 3'd2,
		KIND_CGB_BOOT = 3'd3,
		KIND_DMG_BOOT = 3'd4,
		KIND_SGB_BOOT = 3'd5,
		KIND_CHEAT    = 3'd6
	} download_kind_t;

	////////////////////////////////////////
	// Host file indices
	////////////////////////////////////////

	// Cart matches on the low six index bits, or on the alternate index
	localparam logic [5:0]         IDX_CART_LOW = 6'h01;
	localparam logic [INDEX_W-1:0] IDX_CART_ALT = 8'h80;
	localparam logic [INDEX_W-1:0] IDX_PALETTE  = 8'h03;
	localparam logic [INDEX_W-1:0] IDX_CGB_BOOT = 8'h04;
	localparam logic [INDEX_W-1:0] IDX_DMG_BOOT = 8'h05;
	localparam logic [INDEX_W-1:0] IDX_SGB_BOOT = 8'h06;

	// Checked ahead of the cart rule
	localparam logic [INDEX_W-1:0] IDX_CHEAT    = 8'hFF;

	////////////////////////////////////////
	// Palette
	////////////////////////////////////////

	localparam int PALETTE_W = 128;

	typedef logic [PALETTE_W-1:0] palette_t;

	// Four 24-bit DMG shades at the top, low 32 bits spare
	localparam palette_t PALETTE_DEFAULT = 128'h828214517356305A5F1A3B4900000000;

	////////////////////////////////////////
	// Cheat codes
	////////////////////////////////////////

	localparam int CHEAT_W = 128;

	// Flags 127:96, address 95:64, compare 63:32, replace 31:0
	typedef logic [CHEAT_W-1:0] cheat_code_t;

	////////////////////////////////////////
	// Bootrom checksums
	////////////////////////////////////////

	localparam int CHECKSUM_W = 18;

	typedef logic [CHECKSUM_W-1:0] checksum_t;

	// Byte sums of the known CGB bootroms that support GBA mode
	localparam checksum_t MISTER_CGB0_CHECKSUM  = 18'h2CE10;
	localparam checksum_t ORIGINAL_CGB_CHECKSUM = 18'h2F3EA;

endpackage

`default_nettype wire

// ==== download_decoder.sv ====
// Registers the host download stream and tags each word with the kind of its download
`default_nettype none

module download_decoder
	import gb_loader_pkg::*;
(
	input  wire logic                    clk_sys,
	input  wire logic                    reset,

	input  wire logic                    ioctl_download,
	input  wire logic [INDEX_W-1:0]      ioctl_index,
	input  wire logic                    ioctl_wr,
	input  wire logic [ADDR_W-1:0]       ioctl_addr,
	input  wire word_t                   ioctl_dout,

	output      logic                    word_valid,
	output      download_kind_t          word_kind,
	output      logic [CHEAT_ADDR_W-1:0] word_addr,
	output      word_t                   word_data,
	output      download_kind_t          dl_kind,
	output      logic                    dl_start
);

	download_kind_t index_kind;
	logic           download_prev;

	////////////////////////////////////////
	// File index classification
	////////////////////////////////////////

	// Cheat index is checked before the cart rule
	always_comb begin
		if (ioctl_index == IDX_CHEAT) begin
			index_kind = KIND_CHEAT;
		end else if (ioctl_index[5:0] == IDX_CART_LOW || ioctl_index == IDX_CART_ALT) begin
			index_kind = KIND_CART;
		end else if (ioctl_index == IDX_PALETTE) begin
			index_kind = KIND_PALETTE;
		end else if (ioctl_index == IDX_CGB_BOOT) begin
			index_kind = KIND_CGB_BOOT;
		end else if (ioctl_index == IDX_DMG_BOOT) begin
			index_kind = KIND_DMG_BOOT;
		end else if (ioctl_index == IDX_SGB_BOOT) begin
			index_kind = KIND_SGB_BOOT;
		end else begin
			index_kind = KIND_NONE;
		end
	end

	////////////////////////////////////////
	// Download level and start strobe
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_prev <= 1'b0;
			dl_start      <= 1'b0;
			dl_kind       <= KIND_NONE;
		end else begin
			download_prev <= ioctl_download;
			dl_start      <= ioctl_download & ~download_prev;
			dl_kind       <= ioctl_download ? index_kind : KIND_NONE;
		end
	end

	////////////////////////////////////////
	// Word stage
	////////////////////////////////////////

	// Only writes inside a download become word strobes
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			word_valid <= 1'b0;
		end else begin
			word_valid <= ioctl_wr & ioctl_download;
		end
	end

	// Payload travels alongside the strobe
	always_ff @(posedge clk_sys) begin
		word_kind <= index_kind;
		word_addr <= ioctl_addr[CHEAT_ADDR_W-1:0];
		word_data <= ioctl_dout;
	end

endmodule

`default_nettype wire

// ==== palette_store.sv ====
// Holds the 128-bit DMG palette, shifted in one byte-swapped word per palette download strobe
`default_nettype none

module palette_store
	import gb_loader_pkg::*;
(
	input  wire logic           clk_sys,
	input  wire logic           reset,

	input  wire logic           word_valid,
	input  wire download_kind_t word_kind,
	input  wire word_t          word_data,

	output      palette_t       palette
);

	logic  palette_word;
	word_t swapped_word;

	assign palette_word = word_valid && (word_kind == KIND_PALETTE);

	// Palette files are stored big endian, the host bus is little endian
	assign swapped_word = {word_data[7:0], word_data[15:8]};

	////////////////////////////////////////
	// Shift register
	////////////////////////////////////////

	// Oldest word ends up at the top, so the first four 24-bit
	// shades of the file land in 127:32 after a full load
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			palette <= PALETTE_DEFAULT;
		end else if (palette_word) begin
			palette <= {palette[PALETTE_W-WORD_W-1:0], swapped_word};
		end
	end

endmodule

`default_nettype wire

// ==== cheat_code_assembler.sv ====
// Builds 128-bit cheat codes from addressed download words and strobes each complete code
`default_nettype none

module cheat_code_assembler
	import gb_loader_pkg::*;
(
	input  wire logic                    clk_sys,
	input  wire logic                    reset,

	input  wire logic                    word_valid,
	input  wire download_kind_t          word_kind,
	input  wire logic [CHEAT_ADDR_W-1:0] word_addr,
	input  wire word_t                   word_data,
	input  wire download_kind_t          dl_kind,

	output      cheat_code_t             cheat_code,
	output      logic                    cheat_valid,
	output      logic                    cheat_reset
);

	localparam logic [CHEAT_ADDR_W-1:0] ADDR_FIRST = 4'd0;
	localparam logic [CHEAT_ADDR_W-1:0] ADDR_LAST  = 4'd14;

	logic cheat_word;
	logic flush_needed;

	assign cheat_word = word_valid && (word_kind == KIND_CHEAT);

	// A new cheat file starts at address 0; carts and palettes also drop all codes
	assign flush_needed = (cheat_word && word_addr == ADDR_FIRST) ||
		dl_kind == KIND_CART || dl_kind == KIND_PALETTE;

	////////////////////////////////////////
	// Field registers
	////////////////////////////////////////

	// Each 32-bit field arrives low half first
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_code <= '0;
		end else if (cheat_word) begin
			case (word_addr)
				4'd0:    cheat_code[111:96]  <= word_data;
				4'd2:    cheat_code[127:112] <= word_data;
				4'd4:    cheat_code[79:64]   <= word_data;
				4'd6:    cheat_code[95:80]   <= word_data;
				4'd8:    cheat_code[47:32]   <= word_data;
				4'd10:   cheat_code[63:48]   <= word_data;
				4'd12:   cheat_code[15:0]    <= word_data;
				4'd14:   cheat_code[31:16]   <= word_data;
				// Odd byte addresses carry no word
				default: cheat_code          <= cheat_code;
			endcase
		end
	end

	////////////////////////////////////////
	// Strobes
	////////////////////////////////////////

	// cheat_valid rises with the last field, so the code is whole while it is high
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_valid <= 1'b0;
			cheat_reset <= 1'b0;
		end else begin
			cheat_valid <= cheat_word && (word_addr == ADDR_LAST);
			cheat_reset <= flush_needed;
		end
	end

endmodule

`default_nettype wire

// ==== bootrom_checker.sv ====
// Tracks custom bootrom loads, sums the CGB bootrom bytes and derives the boot feature flags
`default_nettype none

module bootrom_checker
	import gb_loader_pkg::*;
(
	input  wire logic           clk_sys,
	input  wire logic           reset,

	input  wire logic           word_valid,
	input  wire download_kind_t word_kind,
	input  wire word_t          word_data,
	input  wire download_kind_t dl_kind,
	input  wire logic           dl_start,
	input  wire logic           is_gbc,

	output      logic           fastboot_available,
	output      logic           boot_gba_available,
	output      logic           real_cgb_boot
);

	logic      custom_cgb_boot;
	logic      custom_dmg_boot;
	checksum_t checksum_cgb;
	checksum_t byte_sum;
	logic      cgb_word;
	logic      mister_cgb_boot;

	assign cgb_word = word_valid && (word_kind == KIND_CGB_BOOT);

	// Both bytes of the word, zero extended before the add
	assign byte_sum = checksum_cgb
		+ {{(CHECKSUM_W-8){1'b0}}, word_data[15:8]}
		+ {{(CHECKSUM_W-8){1'b0}}, word_data[7:0]};

	////////////////////////////////////////
	// Sticky custom bootrom flags
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			custom_cgb_boot <= 1'b0;
			custom_dmg_boot <= 1'b0;
		end else begin
			if (dl_kind == KIND_CGB_BOOT) begin
				custom_cgb_boot <= 1'b1;
			end
			if (dl_kind == KIND_DMG_BOOT) begin
				custom_dmg_boot <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// CGB bootrom checksum
	////////////////////////////////////////

	// The host sends no word in the start cycle, so clear and add never meet
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			checksum_cgb <= '0;
		end else if (dl_start && dl_kind == KIND_CGB_BOOT) begin
			checksum_cgb <= '0;
		end else if (cgb_word) begin
			checksum_cgb <= byte_sum;
		end
	end

	////////////////////////////////////////
	// Derived flags
	////////////////////////////////////////

	assign mister_cgb_boot = (checksum_cgb == MISTER_CGB0_CHECKSUM);
	assign real_cgb_boot   = (checksum_cgb == ORIGINAL_CGB_CHECKSUM);

	// GBA mode needs a bootrom known to handle it
	assign boot_gba_available = !custom_cgb_boot || real_cgb_boot || mister_cgb_boot;

	// Fast boot only works with the stock core bootroms
	assign fastboot_available = !((is_gbc && custom_cgb_boot && !mister_cgb_boot) ||
		(!is_gbc && custom_dmg_boot));

endmodule

`default_nettype wire

// ==== gb_loader_top.sv ====
// Download side of the console top level; connects the stream decoder to palette, cheat and boot logic
`default_nettype none

module gb_loader_top
	import gb_loader_pkg::*;
(
	input  wire logic               clk_sys,
	input  wire logic               reset,

	// Host download stream
	input  wire logic               ioctl_download,
	input  wire logic [INDEX_W-1:0] ioctl_index,
	input  wire logic               ioctl_wr,
	input  wire logic [ADDR_W-1:0]  ioctl_addr,
	input  wire word_t              ioctl_dout,

	input  wire logic               is_gbc,

	output      palette_t           palette,
	output      cheat_code_t        cheat_code,
	output      logic               cheat_valid,
	output      logic               cheat_reset,
	output      logic               fastboot_available,
	output      logic               boot_gba_available,
	output      logic               real_cgb_boot
);

	logic                    word_valid;
	download_kind_t          word_kind;
	logic [CHEAT_ADDR_W-1:0] word_addr;
	word_t                   word_data;
	download_kind_t          dl_kind;
	logic                    dl_start;

	////////////////////////////////////////
	// Stream decode
	////////////////////////////////////////

	download_decoder u_download_decoder (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.word_valid     (word_valid),
		.word_kind      (word_kind),
		.word_addr      (word_addr),
		.word_data      (word_data),
		.dl_kind        (dl_kind),
		.dl_start       (dl_start)
	);

	////////////////////////////////////////
	// Word consumers
	////////////////////////////////////////

	palette_store u_palette_store (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.word_valid (word_valid),
		.word_kind  (word_kind),
		.word_data  (word_data),
		.palette    (palette)
	);

	cheat_code_assembler u_cheat_code_assembler (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.word_valid  (word_valid),
		.word_kind   (word_kind),
		.word_addr   (word_addr),
		.word_data   (word_data),
		.dl_kind     (dl_kind),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_reset (cheat_reset)
	);

	bootrom_checker u_bootrom_checker (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.word_valid         (word_valid),
		.word_kind          (word_kind),
		.word_data          (word_data),
		.dl_kind            (dl_kind),
		.dl_start           (dl_start),
		.is_gbc             (is_gbc),
		.fastboot_available (fastboot_available),
		.boot_gba_available (boot_gba_available),
		.real_cgb_boot      (real_cgb_boot)
	);

endmodule

`default_nettype wire

// ==== gb_loader_tb.sv ====
// Self-checking testbench for the download side of the console top level; compile from gb_loader.f
`default_nettype none

module gb_loader_tb
	import gb_loader_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_ROWS     = 8;
	localparam int SETTLE_LIMIT = 20;

	// Data modes of a table row
	localparam int MODE_FIXED  = 0;
	localparam int MODE_RANDOM = 1;
	localparam int MODE_FILL   = 2;

	typedef struct {
		string              name;
		logic [INDEX_W-1:0] index;
		int                 words;
		int                 mode;
		checksum_t          target;
		logic               gbc;
	} test_row_t;

	logic               clk_sys;
	logic               reset;
	logic               ioctl_download;
	logic [INDEX_W-1:0] ioctl_index;
	logic               ioctl_wr;
	logic [ADDR_W-1:0]  ioctl_addr;
	word_t              ioctl_dout;
	logic               is_gbc;
	palette_t           palette;
	cheat_code_t        cheat_code;
	logic               cheat_valid;
	logic               cheat_reset;
	logic               fastboot_available;
	logic               boot_gba_available;
	logic               real_cgb_boot;

	test_row_t rows [NUM_ROWS];
	integer    seed;
	int        error_count;
	int        check_count;

	// Reference model state
	palette_t    model_palette;
	cheat_code_t model_cheat;
	checksum_t   model_checksum;
	logic        model_custom_cgb;
	logic        model_custom_dmg;

	gb_loader_top DUT (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.ioctl_download     (ioctl_download),
		.ioctl_index        (ioctl_index),
		.ioctl_wr           (ioctl_wr),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout),
		.is_gbc             (is_gbc),
		.palette            (palette),
		.cheat_code         (cheat_code),
		.cheat_valid        (cheat_valid),
		.cheat_reset        (cheat_reset),
		.fastboot_available (fastboot_available),
		.boot_gba_available (boot_gba_available),
		.real_cgb_boot      (real_cgb_boot)
	);

	always #50 clk_sys = ~clk_sys;

	////////////////////////////////////////
	// Checking and reference model
	////////////////////////////////////////

	task automatic compare(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Error: %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// Cheat index wins over the cart rule
	function automatic download_kind_t kind_of_index(input logic [INDEX_W-1:0] index);
		if (index == IDX_CHEAT) begin
			return KIND_CHEAT;
		end
		if (index[5:0] == IDX_CART_LOW || index == IDX_CART_ALT) begin
			return KIND_CART;
		end
		case (index)
			IDX_PALETTE:  return KIND_PALETTE;
			IDX_CGB_BOOT: return KIND_CGB_BOOT;
			IDX_DMG_BOOT: return KIND_DMG_BOOT;
			IDX_SGB_BOOT: return KIND_SGB_BOOT;
			default:      return KIND_NONE;
		endcase
	endfunction

	// Fill mode spends the remaining byte sum greedily, then sends zeros
	task automatic make_word(input test_row_t row, input int i, inout int remaining,
		output word_t w);
		if (row.mode == MODE_RANDOM) begin
			w = word_t'($random(seed));
		end else if (row.mode == MODE_FILL) begin
			if (remaining >= 510) begin
				w = 16'hFFFF;
				remaining -= 510;
			end else if (remaining > 255) begin
				w = {8'hFF, 8'(remaining - 255)};
				remaining = 0;
			end else begin
				w = {8'h00, 8'(remaining)};
				remaining = 0;
			end
		end else begin
			w = word_t'(32'h1F2E + i * 32'h0D3B);
		end
	endtask

	task automatic model_word(input download_kind_t kind, input logic [3:0] addr,
		input word_t w);
		if (kind == KIND_PALETTE) begin
			model_palette = {model_palette[111:0], w[7:0], w[15:8]};
		end else if (kind == KIND_CGB_BOOT) begin
			model_checksum = model_checksum + checksum_t'(w[15:8]) + checksum_t'(w[7:0]);
		end else if (kind == KIND_CHEAT) begin
			case (addr)
				4'd0:  model_cheat[111:96]  = w;
				4'd2:  model_cheat[127:112] = w;
				4'd4:  model_cheat[79:64]   = w;
				4'd6:  model_cheat[95:80]   = w;
				4'd8:  model_cheat[47:32]   = w;
				4'd10: model_cheat[63:48]   = w;
				4'd12: model_cheat[15:0]    = w;
				4'd14: model_cheat[31:16]   = w;
				default: ;
			endcase
		end
	endtask

	task automatic check_flags(input string name, input logic gbc);
		logic real_exp;
		logic gba_exp;
		logic fast_exp;
		real_exp = (model_checksum == ORIGINAL_CGB_CHECKSUM);
		// GBA mode needs the stock bootrom or one of the two known images
		gba_exp = 1'b1;
		if (model_custom_cgb && model_checksum != ORIGINAL_CGB_CHECKSUM &&
			model_checksum != MISTER_CGB0_CHECKSUM) begin
			gba_exp = 1'b0;
		end
		// Each console mode only looks at its own custom bootrom
		fast_exp = 1'b1;
		if (gbc && model_custom_cgb && model_checksum != MISTER_CGB0_CHECKSUM) begin
			fast_exp = 1'b0;
		end
		if (!gbc && model_custom_dmg) begin
			fast_exp = 1'b0;
		end
		compare({name, " real_cgb_boot"}, 128'(real_exp), 128'(real_cgb_boot));
		compare({name, " boot_gba_available"}, 128'(gba_exp), 128'(boot_gba_available));
		compare({name, " fastboot_available"}, 128'(fast_exp), 128'(fastboot_available));
	endtask

	////////////////////////////////////////
	// One download per table row
	////////////////////////////////////////

	task automatic apply_row(input test_row_t row);
		download_kind_t kind;
		int             remaining;
		int             cycle;
		int             i;
		int             valid_seen;
		logic           word_here;
		logic           exp_valid;
		logic           exp_reset;
		word_t          w;
		cheat_code_t    pulse_code;
		kind       = kind_of_index(row.index);
		remaining  = int'(row.target);
		valid_seen = 0;
		pulse_code = '0;
		cycle      = 0;
		if (kind == KIND_CGB_BOOT) begin
			model_checksum   = '0;
			model_custom_cgb = 1'b1;
		end
		if (kind == KIND_DMG_BOOT) begin
			model_custom_dmg = 1'b1;
		end
		// Keeps going until a cheat pulse shows up or the limit is hit
		while ((cycle < row.words + 4 || (kind == KIND_CHEAT && valid_seen == 0)) &&
			cycle < row.words + SETTLE_LIMIT) begin
			@(posedge clk_sys);
			if (cycle == 0) begin
				ioctl_download <= 1'b1;
				ioctl_index    <= row.index;
				is_gbc         <= row.gbc;
			end else if (cycle <= row.words) begin
				make_word(row, cycle - 1, remaining, w);
				ioctl_wr   <= 1'b1;
				ioctl_addr <= ADDR_W'(2 * (cycle - 1));
				ioctl_dout <= w;
				model_word(kind, 4'(2 * (cycle - 1)), w);
				if (kind == KIND_CHEAT && 4'(2 * (cycle - 1)) == 4'd14) begin
					pulse_code = model_cheat;
				end
			end else begin
				ioctl_wr       <= 1'b0;
				ioctl_download <= 1'b0;
			end
			@(negedge clk_sys);
			// A word driven in cycle 1+i shows on the strobes in cycle 3+i
			i         = cycle - 3;
			word_here = (i >= 0) && (i < row.words);
			exp_valid = kind == KIND_CHEAT && word_here && 4'(2 * i) == 4'd14;
			exp_reset = (kind == KIND_CHEAT && word_here && 4'(2 * i) == 4'd0) ||
				((kind == KIND_CART || kind == KIND_PALETTE) &&
				cycle >= 2 && cycle <= row.words + 2);
			compare({row.name, " cheat_valid"}, 128'(exp_valid), 128'(cheat_valid));
			compare({row.name, " cheat_reset"}, 128'(exp_reset), 128'(cheat_reset));
			if (cheat_valid === 1'b1) begin
				valid_seen++;
				compare({row.name, " cheat_code at pulse"}, pulse_code, cheat_code);
			end
			cycle++;
		end
		if (kind == KIND_CHEAT) begin
			if (valid_seen == 0) begin
				error_count++;
				$display("Timed out waiting for cheat_valid in %s", row.name);
			end
			compare({row.name, " cheat_valid pulses"}, 128'(1), 128'(valid_seen));
		end
		compare({row.name, " palette"}, model_palette, palette);
		compare({row.name, " cheat_code"}, model_cheat, cheat_code);
		check_flags(row.name, row.gbc);
		// Same flags seen from the other console mode
		@(posedge clk_sys);
		is_gbc <= ~row.gbc;
		@(negedge clk_sys);
		check_flags({row.name, " other mode"}, ~row.gbc);
	endtask

	task automatic build_table();
		rows[0] = '{"palette_random", IDX_PALETTE, 8, MODE_RANDOM, 18'h0, 1'b0};
		rows[1] = '{"cheat_fixed", IDX_CHEAT, 8, MODE_FIXED, 18'h0, 1'b0};
		rows[2] = '{"cgb_boot_random", IDX_CGB_BOOT, 64, MODE_RANDOM, 18'h0, 1'b1};
		rows[3] = '{"cgb_boot_original", IDX_CGB_BOOT, 384, MODE_FILL,
			ORIGINAL_CGB_CHECKSUM, 1'b1};
		rows[4] = '{"cgb_boot_mister", IDX_CGB_BOOT, 384, MODE_FILL,
			MISTER_CGB0_CHECKSUM, 1'b1};
		rows[5] = '{"dmg_boot_fixed", IDX_DMG_BOOT, 32, MODE_FIXED, 18'h0, 1'b0};
		rows[6] = '{"cart_alt_index", IDX_CART_ALT, 16, MODE_FIXED, 18'h0, 1'b1};
		rows[7] = '{"cart_low_bits", 8'h41, 16, MODE_RANDOM, 18'h0, 1'b0};
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		seed             = 6857;
		error_count      = 0;
		check_count      = 0;
		clk_sys          = 1'b0;
		reset            = 1'b1;
		ioctl_download   = 1'b0;
		ioctl_index      = '0;
		ioctl_wr         = 1'b0;
		ioctl_addr       = '0;
		ioctl_dout       = '0;
		is_gbc           = 1'b0;
		model_palette    = PALETTE_DEFAULT;
		model_cheat      = '0;
		model_checksum   = '0;
		model_custom_cgb = 1'b0;
		model_custom_dmg = 1'b0;
		build_table();

		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);

		// Reset values
		compare("reset palette", PALETTE_DEFAULT, palette);
		compare("reset cheat_code", 128'(0), cheat_code);
		compare("reset cheat_valid", 128'(0), 128'(cheat_valid));
		compare("reset cheat_reset", 128'(0), 128'(cheat_reset));
		compare("reset fastboot_available", 128'(1), 128'(fastboot_available));
		compare("reset boot_gba_available", 128'(1), 128'(boot_gba_available));
		compare("reset real_cgb_boot", 128'(0), 128'(real_cgb_boot));

		for (int r = 0; r < NUM_ROWS; r++) begin
			apply_row(rows[r]);
		end

		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== gb_loader.f ====
gb_loader_pkg.sv
download_decoder.sv
palette_store.sv
cheat_code_assembler.sv
bootrom_checker.sv
gb_loader_top.sv
gb_loader_tb.sv

// ==== Makefile ====
# Verilator simulation of the loader testbench

VERILATOR ?= verilator
TOP       ?= gb_loader_tb
FILELIST  ?= gb_loader.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --timescale $(TIMESCALE)
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: sim clean

# Output goes to the terminal; status is set by the pass message search
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } /$(PASS_TEXT)/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)
